/* Bender.yml */
package:
  name: tile_game

sources:
  - include_dirs:
      - hw
    files:
      - hw/tile_pkg.sv
      - hw/tile_cen.sv
      - hw/tile_timing.sv
      - hw/tile_char_fetch.sv
      - hw/tile_rom_port.sv
      - hw/tile_colmix.sv
      - hw/tile_game.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tile_rom_model.sv
      - verif/tile_game_tb.sv

/* hw/tile_cen.sv */
module tile_cen(
    input  logic clk,
    input  logic rst,
    output logic pxl2_cen,
    output logic pxl_cen
);

logic [2:0] cnt;

always_ff @(posedge clk) begin
    if (rst) begin
        cnt      <= '0;
        pxl2_cen <= 1'b0;
        pxl_cen  <= 1'b0;
    end else begin
        cnt      <= cnt + 3'd1;
        pxl2_cen <= cnt[1:0] == 2'd3;
        pxl_cen  <= cnt == 3'd7;
    end
end

// Pixel enable sits on a double-pixel one, and the next double-pixel
// enable four clocks on is the half-way one
a_cen_phase: assert property (@(posedge clk) disable iff (rst)
    pxl_cen |-> pxl2_cen ##4 (pxl2_cen && !pxl_cen));

endmodule

/* hw/tile_char_fetch.sv */
`include "tile_macros.svh"

module tile_char_fetch(
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,
    input  tile_pkg::raster_t   raster,
    input  logic                flip,
    // CPU map writes
    input  logic [2:0]          cpu_addr,
    input  tile_pkg::cpu_data_t cpu_dout,
    input  logic [1:0]          dsn,
    input  logic                char_cs,
    // Pattern ROM
    input  logic                char_ok,
    input  tile_pkg::rom_word_t char_data,
    output logic [10:0]         char_addr,
    output tile_pkg::pix_t      pix
);

localparam int MAP_WORDS = `MAP_COLS * `MAP_ROWS;

tile_pkg::cpu_data_t    map_ram [MAP_WORDS];
tile_pkg::fetch_state_t state;
tile_pkg::hcnt_t        nx_h;
tile_pkg::vcnt_t        nx_v;
tile_pkg::tile_code_t   code;
tile_pkg::rom_word_t    shift;
tile_pkg::rom_word_t    cur;
logic [1:0]             map_col;
logic                   map_row;
logic [2:0]             tile_row;
logic [2:0]             map_idx;
logic                   col_start;
logic                   fetch_go;

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < MAP_WORDS; i++) begin
            map_ram[i] <= '0;
        end
    end else if (char_cs) begin
        if (!dsn[0]) begin
            map_ram[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        if (!dsn[1]) begin
            map_ram[cpu_addr][15:8] <= cpu_dout[15:8];
        end
    end
end

// Position of the column after this one, wrapping into the next line
always_comb begin
    nx_h = raster.hdump + tile_pkg::hcnt_t'(8);
    nx_v = raster.vdump;
    if (nx_h >= tile_pkg::hcnt_t'(`H_TOTAL)) begin
        nx_h = nx_h - tile_pkg::hcnt_t'(`H_TOTAL);
        nx_v = raster.vdump == tile_pkg::vcnt_t'(`V_TOTAL - 1) ? '0 : raster.vdump + 9'd1;
    end
end

// Flip mirrors map column, map row and tile row
assign map_col   = flip ? ~nx_h[4:3] : nx_h[4:3];
assign map_row   = flip ? ~nx_v[3]   : nx_v[3];
assign tile_row  = flip ? ~nx_v[2:0] : nx_v[2:0];
assign map_idx   = 3'(map_row * `MAP_COLS + map_col);
assign code      = map_ram[map_idx][7:0];
assign col_start = pxl_cen && raster.hdump[2:0] == 3'd0;

// Sequence starts on the last line before the visible area
assign fetch_go  = col_start && (state != tile_pkg::FETCH_IDLE ||
                   (raster.hstart && raster.vdump == tile_pkg::vcnt_t'(`V_TOTAL - 1)));

always_ff @(posedge clk) begin
    if (rst) begin
        state     <= tile_pkg::FETCH_IDLE;
        char_addr <= '0;
    end else if (fetch_go) begin
        char_addr <= {code, tile_row};
        state     <= tile_pkg::FETCH_WAIT;
    end else if (state == tile_pkg::FETCH_WAIT && char_ok) begin
        state <= tile_pkg::FETCH_DONE;
    end
end

// Port holds the row until the next request, so a new column loads it directly
assign cur = raster.hdump[2:0] != 3'd0 ? shift : char_data;

always_ff @(posedge clk) begin
    if (pxl_cen) begin
        shift <= flip ? cur >> 4 : cur << 4;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        pix.index <= '0;
        pix.hb    <= 1'b1;
        pix.vb    <= 1'b1;
        pix.hs    <= 1'b0;
        pix.vs    <= 1'b0;
    end else if (pxl_cen) begin
        pix.index <= flip ? cur[3:0] : cur[31:28];
        pix.hb    <= raster.hb;
        pix.vb    <= raster.vb;
        pix.hs    <= raster.hs;
        pix.vs    <= raster.vs;
    end
end

// Row for the coming column back from the bank by its boundary
a_row_ready: assert property (@(posedge clk) disable iff (rst)
    col_start && state != tile_pkg::FETCH_IDLE |-> char_ok);

// Bank round trip within one column
a_deadline: assert property (@(posedge clk) disable iff (rst)
    $rose(state == tile_pkg::FETCH_WAIT) |-> ##[0:`ROM_DEADLINE] char_ok);

endmodule

/* hw/tile_colmix.sv */
module tile_colmix(
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,
    input  tile_pkg::pix_t      pix,
    // CPU palette writes
    input  logic [3:0]          cpu_addr,
    input  tile_pkg::cpu_data_t cpu_dout,
    input  logic [1:0]          dsn,
    input  logic                pal_cs,
    // Video out
    output tile_pkg::rgb_t      color,
    output logic                LHBL_dly,
    output logic                LVBL_dly,
    output logic                HS,
    output logic                VS
);

tile_pkg::cpu_data_t pal_ram [16];
tile_pkg::cpu_data_t pal_word;
logic                blank;

always_ff @(posedge clk) begin
    if (pal_cs) begin
        if (!dsn[0]) begin
            pal_ram[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        if (!dsn[1]) begin
            pal_ram[cpu_addr][15:8] <= cpu_dout[15:8];
        end
    end
end

assign pal_word = pal_ram[pix.index];
assign blank    = pix.hb || pix.vb;

// Colour and syncs leave on the same enable
always_ff @(posedge clk) begin
    if (rst) begin
        color    <= '0;
        LHBL_dly <= 1'b0;
        LVBL_dly <= 1'b0;
        HS       <= 1'b0;
        VS       <= 1'b0;
    end else if (pxl_cen) begin
        if (blank) begin
            color <= '0;
        end else begin
            // 5:5:5 with red in the low bits
            color.red   <= pal_word[4:0];
            color.green <= pal_word[9:5];
            color.blue  <= pal_word[14:10];
        end
        LHBL_dly <= !pix.hb;
        LVBL_dly <= !pix.vb;
        HS       <= pix.hs;
        VS       <= pix.vs;
    end
end

endmodule

/* hw/tile_game.sv */
module tile_game(
    input  logic                rst,
    input  logic                clk,
    output logic                pxl2_cen,
    output logic                pxl_cen,
    output logic [4:0]          red,
    output logic [4:0]          green,
    output logic [4:0]          blue,
    output logic                LHBL_dly,
    output logic                LVBL_dly,
    output logic                HS,
    output logic                VS,
    input  logic                flip,
    // CPU bus
    input  logic [3:0]          cpu_addr,
    input  tile_pkg::cpu_data_t cpu_dout,
    input  logic [1:0]          dsn,
    input  logic                char_cs,
    input  logic                pal_cs,
    // SDRAM bank, read only
    output tile_pkg::rom_addr_t ba_addr,
    output logic                ba_rd,
    input  logic                ba_ack,
    input  logic                ba_rdy,
    input  tile_pkg::rom_word_t data_read
);

tile_pkg::raster_t   raster;
tile_pkg::pix_t      pix;
tile_pkg::rgb_t      color;
tile_pkg::rom_word_t char_data;
logic [10:0]         char_addr;
logic                char_ok;

assign red   = color.red;
assign green = color.green;
assign blue  = color.blue;

tile_cen u_cen(.*);

tile_timing u_timing(.*);

// Map holds eight words, so only the low address bits reach it
tile_char_fetch u_char(
    .cpu_addr   ( cpu_addr[2:0] ),
    .*
);

tile_rom_port u_rom(.*);

tile_colmix u_colmix(.*);

endmodule

/* hw/tile_macros.svh */
`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

// Screen geometry, pixels and lines
`define H_TOTAL      48
`define H_ACTIVE     32
`define V_TOTAL      24
`define V_ACTIVE     16

// Sync placement
`define HS_START     36
`define HS_LEN       4
`define VS_START     18
`define VS_LEN       2

// Character map in tiles
`define MAP_COLS     4
`define MAP_ROWS     2

// Clocks one tile column leaves for its pattern fetch
`define ROM_DEADLINE 64

`endif

/* hw/tile_pkg.sv */
package tile_pkg;

    // Raster counters
    typedef logic [8:0]  hcnt_t;
    typedef logic [8:0]  vcnt_t;

    typedef logic [3:0]  pxl_t;
    typedef logic [7:0]  tile_code_t;

    // Bank word address and one pattern row, leftmost pixel in the top nibble
    typedef logic [21:0] rom_addr_t;
    typedef logic [31:0] rom_word_t;

    typedef logic [15:0] cpu_data_t;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

    // Timing to fetch
    typedef struct packed {
        hcnt_t hdump;
        vcnt_t vdump;
        logic  hb;
        logic  vb;
        logic  hs;
        logic  vs;
        logic  hstart;
    } raster_t;

    // Fetch to colour mix
    typedef struct packed {
        pxl_t index;
        logic hb;
        logic vb;
        logic hs;
        logic vs;
    } pix_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_DONE
    } fetch_state_t;

endpackage

/* hw/tile_rom_port.sv */
module tile_rom_port(
    input  logic                clk,
    input  logic                rst,
    // Tile fetch side
    input  logic [10:0]         char_addr,
    output logic                char_ok,
    output tile_pkg::rom_word_t char_data,
    // SDRAM bank
    output tile_pkg::rom_addr_t ba_addr,
    output logic                ba_rd,
    input  logic                ba_ack,
    input  logic                ba_rdy,
    input  tile_pkg::rom_word_t data_read
);

logic [10:0] last_addr;
logic        last_valid;
logic        wait_rdy;
logic        data_ok;
logic        new_addr;
logic        start;

assign new_addr = !last_valid || char_addr != last_addr;
assign start    = !ba_rd && !wait_rdy && new_addr;
// Drops the moment the fetch moves on
assign char_ok  = data_ok && !new_addr;

always_ff @(posedge clk) begin
    if (rst) begin
        ba_rd      <= 1'b0;
        wait_rdy   <= 1'b0;
        data_ok    <= 1'b0;
        last_valid <= 1'b0;
        last_addr  <= '0;
    end else if (ba_rd) begin
        if (ba_ack) begin
            ba_rd    <= 1'b0;
            wait_rdy <= 1'b1;
        end
    end else if (wait_rdy) begin
        if (ba_rdy) begin
            wait_rdy <= 1'b0;
            data_ok  <= 1'b1;
        end
    end else if (new_addr) begin
        ba_rd      <= 1'b1;
        data_ok    <= 1'b0;
        last_valid <= 1'b1;
        last_addr  <= char_addr;
    end
end

// Request address and returned row
always_ff @(posedge clk) begin
    if (start) begin
        ba_addr <= tile_pkg::rom_addr_t'(char_addr);
    end
    if (wait_rdy && ba_rdy) begin
        char_data <= data_read;
    end
end

// Bank only answers an acknowledged request
a_rdy_pending: assert property (@(posedge clk) disable iff (rst)
    ba_rdy |-> wait_rdy);

endmodule

/* hw/tile_timing.sv */
`include "tile_macros.svh"

module tile_timing(
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    output tile_pkg::raster_t raster
);

tile_pkg::hcnt_t h_nxt;
tile_pkg::vcnt_t v_nxt;

// Position after the coming pixel enable
always_comb begin
    h_nxt = raster.hdump + 9'd1;
    v_nxt = raster.vdump;
    if (raster.hdump == tile_pkg::hcnt_t'(`H_TOTAL - 1)) begin
        h_nxt = '0;
        if (raster.vdump == tile_pkg::vcnt_t'(`V_TOTAL - 1)) begin
            v_nxt = '0;
        end else begin
            v_nxt = raster.vdump + 9'd1;
        end
    end
end

// Flags come from the next position so they line up with the counters
always_ff @(posedge clk) begin
    if (rst) begin
        // Parked at the end of the first blank line
        raster.hdump  <= tile_pkg::hcnt_t'(`H_TOTAL - 1);
        raster.vdump  <= tile_pkg::vcnt_t'(`V_ACTIVE);
        raster.hb     <= 1'b1;
        raster.vb     <= 1'b1;
        raster.hs     <= 1'b0;
        raster.vs     <= 1'b0;
        raster.hstart <= 1'b0;
    end else if (pxl_cen) begin
        raster.hdump  <= h_nxt;
        raster.vdump  <= v_nxt;
        raster.hb     <= h_nxt >= tile_pkg::hcnt_t'(`H_ACTIVE);
        raster.vb     <= v_nxt >= tile_pkg::vcnt_t'(`V_ACTIVE);
        raster.hs     <= h_nxt >= tile_pkg::hcnt_t'(`HS_START) &&
                         h_nxt <  tile_pkg::hcnt_t'(`HS_START + `HS_LEN);
        raster.vs     <= v_nxt >= tile_pkg::vcnt_t'(`VS_START) &&
                         v_nxt <  tile_pkg::vcnt_t'(`VS_START + `VS_LEN);
        raster.hstart <= h_nxt == '0;
    end
end

endmodule

/* sources.f */
+incdir+hw
hw/tile_pkg.sv
hw/tile_cen.sv
hw/tile_timing.sv
hw/tile_char_fetch.sv
hw/tile_rom_port.sv
hw/tile_colmix.sv
hw/tile_game.sv
verif/tile_rom_model.sv
verif/tile_game_tb.sv

/* verif/tile_game_tb.sv */
`include "tile_macros.svh"

module tile_game_tb;

localparam int PAT_WORDS  = 32;
localparam int PAT_BASE   = 32;
localparam int FRAME_CLKS = 8 * `H_TOTAL * `V_TOTAL;
// Lead-in to the first visible line, four frames and the CPU writes
localparam int CLK_LIMIT  = 5 * FRAME_CLKS + 1000;

logic                clk;
logic                rst;
logic                flip;
logic [3:0]          cpu_addr;
tile_pkg::cpu_data_t cpu_dout;
logic [1:0]          dsn;
logic                char_cs;
logic                pal_cs;
logic                ba_ack;
logic                ba_rdy;
tile_pkg::rom_word_t data_read;
tile_pkg::rom_addr_t ba_addr;
logic                ba_rd;
logic                pxl2_cen;
logic                pxl_cen;
logic [4:0]          red;
logic [4:0]          green;
logic [4:0]          blue;
logic                LHBL_dly;
logic                LVBL_dly;
logic                HS;
logic                VS;

// Map at 00, palette at 08, palette update at 18, pattern rows at 20
logic [31:0]         mem [64];
tile_pkg::rom_word_t pat [PAT_WORDS];
int                  value_errs = 0;
int                  other_errs = 0;
int                  cycles = 0;
int                  frame = 0;
int                  frames_done = 0;
int                  x = 0;
int                  y = 0;
int                  pix_cnt = 0;
int                  hs_cnt = 0;
int                  vs_cnt = 0;
int                  cen_gap = -1;
logic                lhbl_q = 1'b0;
logic                lvbl_q = 1'b0;
logic                hs_q = 1'b0;
logic                vs_q = 1'b0;
logic                rd_q = 1'b0;
logic                ack_q = 1'b0;

tile_game dut_i(.*);

tile_rom_model u_bank(
    .rom ( pat ),
    .*
);

initial begin
    clk = 1'b0;
    forever begin
        #50 clk = ~clk;
    end
end

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        value_errs++;
        $display("ERR %s: got %0h expected %0h", name, got, exp);
    end
endtask

// Colour a pixel should show, packed as blue, green, red
function automatic logic [14:0] expected_rgb(input int px, input int py, input bit flipped);
    int          xx;
    int          yy;
    logic [7:0]  code;
    logic [31:0] row;
    logic [3:0]  idx;
    logic [31:0] entry;
    xx    = flipped ? `H_ACTIVE - 1 - px : px;
    yy    = flipped ? `V_ACTIVE - 1 - py : py;
    code  = mem[(yy / 8) * `MAP_COLS + xx / 8][7:0];
    row   = pat[int'(code) * 8 + yy % 8];
    idx   = row[31 - 4 * (xx % 8) -: 4];
    entry = mem[8 + int'(idx)];
    return {entry[14:10], entry[9:5], entry[4:0]};
endfunction

task automatic check_pixel(input int px, input int py);
    logic [14:0] exp;
    string       at;
    exp = expected_rgb(px, py, frame >= 3);
    at  = $sformatf(" at x=%0d y=%0d frame %0d", px, py, frame);
    check_eq({"red", at}, red, exp[4:0]);
    check_eq({"green", at}, green, exp[9:5]);
    check_eq({"blue", at}, blue, exp[14:10]);
endtask

task automatic cpu_write(input bit to_pal, input logic [3:0] addr, input logic [15:0] data,
                         input logic [1:0] strobes);
    cpu_addr = addr;
    cpu_dout = data;
    dsn      = strobes;
    char_cs  = !to_pal;
    pal_cs   = to_pal;
    @(negedge clk);
    char_cs  = 1'b0;
    pal_cs   = 1'b0;
    dsn      = 2'b11;
endtask

task automatic report_and_finish(input bit timed_out);
    $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0 && !timed_out) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
endtask

initial begin
    $readmemh("verif/tile_input.hex", mem);
    for (int i = 0; i < PAT_WORDS; i++) begin
        pat[i] = mem[PAT_BASE + i];
    end
    rst      = 1'b1;
    flip     = 1'b0;
    cpu_addr = '0;
    cpu_dout = '0;
    dsn      = 2'b11;
    char_cs  = 1'b0;
    pal_cs   = 1'b0;
    repeat (10) @(negedge clk);
    // Outputs while reset is still held
    check_eq("HS", HS, 0);
    check_eq("VS", VS, 0);
    check_eq("LHBL_dly", LHBL_dly, 0);
    check_eq("LVBL_dly", LVBL_dly, 0);
    check_eq("red", red, 0);
    check_eq("green", green, 0);
    check_eq("blue", blue, 0);
    check_eq("ba_rd", ba_rd, 0);
    rst = 1'b0;
    for (int i = 0; i < 8; i++) begin
        cpu_write(1'b0, 4'(i), mem[i][15:0], 2'b00);
    end
    for (int i = 0; i < 16; i++) begin
        cpu_write(1'b1, 4'(i), mem[8 + i][15:0], 2'b00);
    end
    // Single byte palette write part way into frame 2
    while (frame < 2) @(negedge clk);
    repeat (100) @(negedge clk);
    cpu_write(1'b1, mem[24][3:0], mem[26][15:0], mem[25][1:0]);
    if (!mem[25][0]) mem[8 + mem[24][3:0]][7:0] = mem[26][7:0];
    if (!mem[25][1]) mem[8 + mem[24][3:0]][15:8] = mem[26][15:8];
    while (frames_done < 2) @(negedge clk);
    flip = 1'b1;
    while (frames_done < 4) @(negedge clk);
    report_and_finish(1'b0);
end

// Pixel capture, one sample per pixel enable
always @(negedge clk) begin
    if (!rst && pxl_cen) begin
        if (LVBL_dly && !lvbl_q) begin
            if (frame > 0) begin
                check_eq("HS pulses per frame", hs_cnt, `V_TOTAL);
                check_eq("VS pulses per frame", vs_cnt, 1);
            end
            frame   = frame + 1;
            y       = 0;
            pix_cnt = 0;
            hs_cnt  = 0;
            vs_cnt  = 0;
        end
        if (HS && !hs_q) hs_cnt++;
        if (VS && !vs_q) vs_cnt++;
        if (LHBL_dly && !lhbl_q) x = 0;
        if (LHBL_dly && LVBL_dly) begin
            // Frame 2 carries the palette change part way through
            if (frame != 2) check_pixel(x, y);
            x++;
            pix_cnt++;
        end
        if (!LHBL_dly && lhbl_q && LVBL_dly) begin
            check_eq("LHBL_dly pixels per line", x, `H_ACTIVE);
            y++;
        end
        if (!LVBL_dly && lvbl_q) begin
            check_eq("LVBL_dly lines per frame", y, `V_ACTIVE);
            check_eq("LVBL_dly pixels per frame", pix_cnt, `H_ACTIVE * `V_ACTIVE);
            frames_done = frame;
        end
        lhbl_q = LHBL_dly;
        lvbl_q = LVBL_dly;
        hs_q   = HS;
        vs_q   = VS;
    end
end

// Enable spacing in clocks since the last pixel enable
always @(negedge clk) begin
    if (rst) begin
        cen_gap = -1;
    end else if (cen_gap >= 0 || pxl_cen) begin
        cen_gap = (pxl_cen && cen_gap < 0) ? 0 : (cen_gap + 1) % 8;
        check_eq("pxl_cen", pxl_cen, cen_gap == 0);
        check_eq("pxl2_cen", pxl2_cen, cen_gap % 4 == 0);
    end
end

// Bank request rules, values from just before each edge
always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!rst) begin
        assert (!(rd_q && !ack_q) || ba_rd) else begin
            other_errs++;
            $display("Bank read request dropped before its ack at cycle %0d", cycles);
        end
        assert (!ba_rd || ba_addr < PAT_WORDS) else begin
            value_errs++;
            $display("ERR ba_addr: got %0h, outside pattern rows 0 to %0h", ba_addr,
                     PAT_WORDS - 1);
        end
    end
    rd_q  <= ba_rd;
    ack_q <= ba_ack;
end

initial begin
    while (cycles < CLK_LIMIT) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clocks", CLK_LIMIT);
    report_and_finish(1'b1);
end

endmodule

/* verif/tile_input.hex */
// Words 00-07 tile map, 08-17 palette, 18-1a palette update (index, dsn, data)
// Words 20-3f pattern rows, eight 4-bit pixels each, leftmost in the top nibble
@00
0001 0103 0000 0202 0002 0001 0003 0100
@08
0421 7C00 03E0 001F 4210 2D6B 56B5 7FFF
1234 0F0F 3C3C 6318 18C6 2A55 5555 0842
@18
0005 0002 7FA5
@20
01234567 89ABCDEF 76543210 FEDCBA98 55555555 0F0F0F0F 12481248 A5A5A5A5
11223344 55667788 99AABBCC DDEEFF00 5A5A5A5A C3C3C3C3 01010101 FEFEFEFE
00000000 FFFFFFFF 13579BDF 2468ACE0 5F5F5F5F 7E7E7E7E 0A0B0C0D 35353535
F0E1D2C3 B4A59687 78695A4B 3C2D1E0F 55AA55AA 9C9C9C9C 6D6D6D6D 50505050

/* verif/tile_rom_model.sv */
module tile_rom_model(
    input  logic                clk,
    input  logic                rst,
    input  tile_pkg::rom_word_t rom [32],
    input  tile_pkg::rom_addr_t ba_addr,
    input  logic                ba_rd,
    output logic                ba_ack,
    output logic                ba_rdy,
    output tile_pkg::rom_word_t data_read
);

// Ack and ready waits add up to at most 40 clocks
localparam int ACK_MAX = 20;
localparam int RDY_MAX = 20;

initial begin
    int                  ack_wait;
    int                  rdy_wait;
    logic                busy;
    logic                acked;
    tile_pkg::rom_addr_t addr;
    void'($urandom(4300));
    busy      = 1'b0;
    acked     = 1'b0;
    ack_wait  = 0;
    rdy_wait  = 0;
    addr      = '0;
    ba_ack    = 1'b0;
    ba_rdy    = 1'b0;
    data_read = '0;
    forever begin
        @(negedge clk);
        ba_ack = 1'b0;
        ba_rdy = 1'b0;
        if (rst) begin
            busy = 1'b0;
        end else if (!busy && ba_rd) begin
            // New request, both waits drawn up front
            busy     = 1'b1;
            acked    = 1'b0;
            addr     = ba_addr;
            ack_wait = $urandom_range(ACK_MAX);
            rdy_wait = $urandom_range(RDY_MAX);
        end
        if (busy && !acked) begin
            if (ack_wait == 0) begin
                ba_ack = 1'b1;
                acked  = 1'b1;
            end else begin
                ack_wait--;
            end
        end else if (busy) begin
            if (rdy_wait == 0) begin
                ba_rdy    = 1'b1;
                data_read = rom[addr];
                busy      = 1'b0;
            end else begin
                rdy_wait--;
            end
        end
    end
end

endmodule
